// File: microwire_pkg.sv
`default_nettype none

package microwire_pkg;

	// Command framing of the 93C46-style interface, 64 x 16 organization
	localparam int unsigned ADDR_W = 6;
	localparam int unsigned OPCODE_W = 2;
	localparam int unsigned HDR_BITS = OPCODE_W + ADDR_W;

	// Wide enough for the longest phase of 16 bits
	localparam int unsigned BIT_CNT_W = 5;

	typedef logic [ADDR_W-1:0] word_addr_t;
	typedef logic [OPCODE_W-1:0] opcode_t;
	typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

	// Only read is served, other opcodes are skipped until deselect
	localparam opcode_t OP_READ = 2'b10;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_HEADER,
		ST_DUMMY,
		ST_DATA,
		ST_IGNORE
	} mw_state_t;

endpackage

`default_nettype wire

// File: nvm_map_pkg.sv
`default_nettype none

package nvm_map_pkg;

	localparam int unsigned WORD_W = 16;

	typedef logic [WORD_W-1:0] nvm_word_t;

	//////////////////////////////////////////////////////////////
	// Word addresses of the NIC configuration map

	// Ethernet address, two bytes per word, low byte first
	localparam int unsigned ADDR_MAC0 = 0;
	localparam int unsigned ADDR_MAC1 = 1;
	localparam int unsigned ADDR_MAC2 = 2;

	localparam int unsigned ADDR_SUB_PID = 11;
	localparam int unsigned ADDR_SUB_VID = 12;
	localparam int unsigned ADDR_PID = 13;
	localparam int unsigned ADDR_VID = 14;

	localparam int unsigned ADDR_CHECKSUM = 63;

	// Sum of all 64 words must land on this value
	localparam nvm_word_t CHECKSUM_TARGET = 16'hBABA;

endpackage

`default_nettype wire

// File: bit_counter.sv
`timescale 1ns/1ns
`default_nettype none

module bit_counter (
	input  logic                     clk_i,
	input  logic                     rst_i,
	input  logic                     load_i,
	input  microwire_pkg::bit_cnt_t  len_i,
	input  logic                     step_i,
	output logic                     done_o
);
	import microwire_pkg::*;

	bit_cnt_t cnt_q;
	logic running;

	assign running = (cnt_q != '0);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cnt_q <= '0;
		end else if (load_i) begin
			cnt_q <= len_i;
		end else if (step_i && running) begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	// Last bit of the phase
	assign done_o = step_i && (cnt_q == bit_cnt_t'(1));

	// A new phase may only start once the previous one has run out
	a_load_when_idle: assert property (@(posedge clk_i) disable iff (rst_i)
		(load_i && (len_i != '0)) |-> !running)
		else $error("bit_counter reloaded while %0d bits remain", cnt_q);

endmodule

`default_nettype wire

// File: cmd_shifter.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_shifter (
	input  logic                       clk_i,
	input  logic                       rst_i,
	input  logic                       shift_i,
	input  logic                       bit_i,
	input  logic                       inc_i,
	output microwire_pkg::opcode_t     opcode_o,
	output microwire_pkg::word_addr_t  addr_o
);
	import microwire_pkg::*;

	opcode_t opcode_q;
	word_addr_t addr_q;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			opcode_q <= '0;
			addr_q <= '0;
		end else if (shift_i) begin
			// Header comes in MSB first, opcode ahead of the address
			{opcode_q, addr_q} <= {opcode_q[0], addr_q, bit_i};
		end else if (inc_i) begin
			// Sequential read, 63 rolls over to 0
			addr_q <= addr_q + 1'b1;
		end
	end

	assign opcode_o = opcode_q;
	assign addr_o = addr_q;

endmodule

`default_nettype wire

// File: read_shifter.sv
`timescale 1ns/1ns
`default_nettype none

module read_shifter (
	input  logic                     clk_i,
	input  logic                     rst_i,
	input  logic                     load_i,
	input  logic                     shift_i,
	input  logic                     drive_i,
	input  nvm_map_pkg::nvm_word_t   word_i,
	output logic                     do_o
);
	import nvm_map_pkg::*;

	nvm_word_t shreg_q;
	logic bit_q;

	always_ff @(posedge clk_i) begin
		if (load_i) begin
			shreg_q <= word_i;
		end else if (shift_i) begin
			shreg_q <= shreg_q << 1;
		end
	end

	// Output bit, held at 0 outside a read so the dummy bit comes out low
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			bit_q <= 1'b0;
		end else if (!drive_i) begin
			bit_q <= 1'b0;
		end else if (load_i) begin
			bit_q <= word_i[WORD_W-1];
		end else if (shift_i) begin
			bit_q <= shreg_q[WORD_W-2];
		end
	end

	assign do_o = drive_i & bit_q;

endmodule

`default_nettype wire

// File: config_rom.sv
`timescale 1ns/1ns
`default_nettype none

module config_rom #(
	parameter logic [23:0] MAC_OUI = '0,
	parameter logic [23:0] MAC_NIC = '0,
	parameter logic [15:0] SUB_PID = '0,
	parameter logic [15:0] SUB_VID = '0,
	parameter logic [15:0] PID = '0,
	parameter logic [15:0] VID = '0
) (
	input  logic                       clk_i,
	input  logic                       rst_i,
	input  microwire_pkg::word_addr_t  addr_i,
	output nvm_map_pkg::nvm_word_t     data_o
);
	import microwire_pkg::*;
	import nvm_map_pkg::*;

	localparam int unsigned DEPTH = 2 ** ADDR_W;

	// Map contents without the checksum word
	function automatic nvm_word_t base_word(input int unsigned a);
		nvm_word_t w;
		case (a)
			ADDR_MAC0: w = {MAC_OUI[15:8], MAC_OUI[23:16]};
			ADDR_MAC1: w = {MAC_NIC[23:16], MAC_OUI[7:0]};
			ADDR_MAC2: w = {MAC_NIC[7:0], MAC_NIC[15:8]};
			ADDR_SUB_PID: w = SUB_PID;
			ADDR_SUB_VID: w = SUB_VID;
			ADDR_PID: w = PID;
			ADDR_VID: w = VID;
			default: w = '0;
		endcase
		return w;
	endfunction

	function automatic nvm_word_t table_sum();
		nvm_word_t acc;
		acc = '0;
		for (int unsigned i = 0; i < DEPTH; i++) begin
			acc = acc + base_word(i);
		end
		return acc;
	endfunction

	// Modulo 2^16, so the full table adds up to the target
	localparam nvm_word_t CHECKSUM_WORD = CHECKSUM_TARGET - table_sum();

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			data_o <= '0;
		end else if (addr_i == word_addr_t'(ADDR_CHECKSUM)) begin
			data_o <= CHECKSUM_WORD;
		end else begin
			data_o <= base_word(int'(addr_i));
		end
	end

endmodule

`default_nettype wire

// File: microwire_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module microwire_sequencer (
	input  logic                     clk_i,
	input  logic                     rst_i,
	input  logic                     sk_i,
	input  logic                     cs_i,
	input  logic                     di_i,
	input  logic                     cnt_done_i,
	input  microwire_pkg::opcode_t   opcode_i,
	output logic                     sk_rise_o,
	output logic                     di_sync_o,
	output logic                     cnt_load_o,
	output microwire_pkg::bit_cnt_t  cnt_len_o,
	output logic                     hdr_shift_o,
	output logic                     addr_inc_o,
	output logic                     word_load_o,
	output logic                     bit_shift_o,
	output logic                     drive_o
);
	import microwire_pkg::*;
	import nvm_map_pkg::*;

	logic [1:0] sk_sync_q;
	logic [1:0] cs_sync_q;
	logic [1:0] di_sync_q;
	logic sk_prev_q;
	logic sk_rise;
	logic sk_fall;
	logic cs_act;
	logic hdr_start;
	logic need_load_q;
	logic word_end_q;
	mw_state_t state_q;
	mw_state_t state_d;

	//////////////////////////////////////////////////////////////
	// Pin synchronizers and sk edge strobes

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			sk_sync_q <= '0;
			cs_sync_q <= '0;
			di_sync_q <= '0;
			sk_prev_q <= 1'b0;
		end else begin
			sk_sync_q <= {sk_sync_q[0], sk_i};
			cs_sync_q <= {cs_sync_q[0], cs_i};
			di_sync_q <= {di_sync_q[0], di_i};
			sk_prev_q <= sk_sync_q[1];
		end
	end

	assign sk_rise = sk_sync_q[1] & ~sk_prev_q;
	assign sk_fall = ~sk_sync_q[1] & sk_prev_q;
	assign cs_act = cs_sync_q[1];
	assign sk_rise_o = sk_rise;
	assign di_sync_o = di_sync_q[1];

	//////////////////////////////////////////////////////////////
	// Command FSM

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (sk_rise && di_sync_q[1]) begin
					state_d = ST_HEADER;
				end
			end
			ST_HEADER: begin
				if (cnt_done_i) begin
					state_d = ST_DUMMY;
				end
			end
			// Opcode is settled one cycle after the last header bit
			ST_DUMMY: begin
				if (opcode_i != OP_READ) begin
					state_d = ST_IGNORE;
				end else if (sk_rise) begin
					state_d = ST_DATA;
				end
			end
			ST_DATA, ST_IGNORE: state_d = state_q;
			default: state_d = ST_IDLE;
		endcase
		if (!cs_act) begin
			state_d = ST_IDLE;
		end
	end

	assign hdr_start = (state_q == ST_IDLE) && (state_d == ST_HEADER);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= ST_IDLE;
			need_load_q <= 1'b0;
			word_end_q <= 1'b0;
		end else begin
			state_q <= state_d;
			// Counter is armed on the sk fall after a phase begins
			if (state_d == ST_IDLE) begin
				need_load_q <= 1'b0;
			end else if (hdr_start || word_load_o) begin
				need_load_q <= 1'b1;
			end else if (sk_fall) begin
				need_load_q <= 1'b0;
			end
			if (addr_inc_o) begin
				word_end_q <= 1'b1;
			end else if (word_load_o || (state_q != ST_DATA)) begin
				word_end_q <= 1'b0;
			end
		end
	end

	// Idle keeps the counter cleared after an abort
	assign cnt_load_o = (state_q == ST_IDLE) || (sk_fall && need_load_q);
	assign cnt_len_o = (state_q == ST_HEADER) ? bit_cnt_t'(HDR_BITS) :
		(state_q == ST_DATA) ? bit_cnt_t'(WORD_W - 1) : '0;

	assign hdr_shift_o = sk_rise && (state_q == ST_HEADER);
	assign word_load_o = sk_rise && (((state_q == ST_DUMMY) && (opcode_i == OP_READ)) ||
		((state_q == ST_DATA) && word_end_q));
	assign bit_shift_o = sk_rise && (state_q == ST_DATA) && !word_end_q;
	// Next address is fetched while the last bit is on the wire
	assign addr_inc_o = (state_q == ST_DATA) && cnt_done_i;
	assign drive_o = (state_q == ST_DUMMY) || (state_q == ST_DATA);

	// Deselect parks the FSM with do_o released
	a_cs_abort: assert property (@(posedge clk_i) disable iff (rst_i)
		!cs_i [*3] |=> (state_q == ST_IDLE) && !drive_o)
		else $error("do_o still driven after cs_i low");

endmodule

`default_nettype wire

// File: eeprom_config_top.sv
`timescale 1ns/1ns
`default_nettype none

module eeprom_config_top #(
	parameter logic [23:0] MAC_OUI = 24'hEC3F05,
	parameter logic [23:0] MAC_NIC = 24'h5A0001,
	parameter logic [15:0] SUB_PID = 16'h6120,
	parameter logic [15:0] SUB_VID = 16'hFACE,
	parameter logic [15:0] PID = 16'hABCD,
	parameter logic [15:0] VID = 16'h8086
) (
	input  logic clk_i,
	input  logic rst_i,
	input  logic sk_i,
	input  logic cs_i,
	input  logic di_i,
	output logic do_o
);
	import microwire_pkg::*;
	import nvm_map_pkg::*;

	logic sk_rise;
	logic di_sync;
	logic cnt_load;
	logic cnt_done;
	logic hdr_shift;
	logic addr_inc;
	logic word_load;
	logic bit_shift;
	logic drive;
	bit_cnt_t cnt_len;
	opcode_t opcode;
	word_addr_t word_addr;
	nvm_word_t rom_data;

	//////////////////////////////////////////////////////////////
	// Microwire front end

	microwire_sequencer sequencer_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.sk_i(sk_i),
		.cs_i(cs_i),
		.di_i(di_i),
		.cnt_done_i(cnt_done),
		.opcode_i(opcode),
		.sk_rise_o(sk_rise),
		.di_sync_o(di_sync),
		.cnt_load_o(cnt_load),
		.cnt_len_o(cnt_len),
		.hdr_shift_o(hdr_shift),
		.addr_inc_o(addr_inc),
		.word_load_o(word_load),
		.bit_shift_o(bit_shift),
		.drive_o(drive)
	);

	bit_counter counter_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.load_i(cnt_load),
		.len_i(cnt_len),
		.step_i(sk_rise),
		.done_o(cnt_done)
	);

	cmd_shifter cmd_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.shift_i(hdr_shift),
		.bit_i(di_sync),
		.inc_i(addr_inc),
		.opcode_o(opcode),
		.addr_o(word_addr)
	);

	//////////////////////////////////////////////////////////////
	// Word table and read path

	config_rom #(
		.MAC_OUI(MAC_OUI),
		.MAC_NIC(MAC_NIC),
		.SUB_PID(SUB_PID),
		.SUB_VID(SUB_VID),
		.PID(PID),
		.VID(VID)
	) rom_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.addr_i(word_addr),
		.data_o(rom_data)
	);

	read_shifter shifter_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.load_i(word_load),
		.shift_i(bit_shift),
		.drive_i(drive),
		.word_i(rom_data),
		.do_o(do_o)
	);

endmodule

`default_nettype wire

// File: tb_microwire_tasks.svh
`ifndef TB_MICROWIRE_TASKS_SVH
`define TB_MICROWIRE_TASKS_SVH

// clk cycles per sk half-period
localparam int HALF_SK = 10;
localparam int DESELECT_LIMIT = 4;
localparam int DEPTH = 2 ** ADDR_W;

//////////////////////////////////////////////////////////////
// Expected contents of the word table

function automatic nvm_word_t map_word(input int unsigned a);
	logic [7:0] mac [0:5];
	nvm_word_t w;
	mac[0] = MAC_OUI[23:16];
	mac[1] = MAC_OUI[15:8];
	mac[2] = MAC_OUI[7:0];
	mac[3] = MAC_NIC[23:16];
	mac[4] = MAC_NIC[15:8];
	mac[5] = MAC_NIC[7:0];
	w = '0;
	// Two MAC bytes per word with the lower numbered byte in the low half
	if (a <= ADDR_MAC2) begin
		w = {mac[2 * a + 1], mac[2 * a]};
	end else if (a == ADDR_SUB_PID) begin
		w = SUB_PID;
	end else if (a == ADDR_SUB_VID) begin
		w = SUB_VID;
	end else if (a == ADDR_PID) begin
		w = PID;
	end else if (a == ADDR_VID) begin
		w = VID;
	end
	return w;
endfunction

function automatic nvm_word_t expected_word(input int unsigned a);
	nvm_word_t acc;
	acc = '0;
	if (a != ADDR_CHECKSUM) begin
		return map_word(a);
	end
	for (int unsigned i = 0; i < ADDR_CHECKSUM; i++) begin
		acc = acc + map_word(i);
	end
	return CHECKSUM_TARGET - acc;
endfunction

//////////////////////////////////////////////////////////////
// Compare tasks and test bookkeeping

task automatic check_word(input nvm_word_t got, input nvm_word_t exp, input string what);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, what, exp, got);
	end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("CHECK FAILED at %0t ns: %s expected %b got %b", $time, what, exp, got);
	end
endtask

task automatic end_test(input string name, input int err_before);
	tests_run++;
	if (errors == err_before) begin
		$display("test %-18s ok", name);
	end else begin
		tests_failed++;
		$display("test %-18s %0d errors", name, errors - err_before);
	end
endtask

//////////////////////////////////////////////////////////////
// Host side of the Microwire bus

task automatic clocks(input int n);
	for (int i = 0; i < n; i++) begin
		@(posedge clk);
	end
endtask

// One sk period with do_o sampled at the end of the low half
task automatic sk_cycle(input logic di_val, output logic sampled);
	@(posedge clk);
	sk <= 1'b0;
	di <= di_val;
	clocks(HALF_SK - 1);
	@(negedge clk);
	sampled = dout;
	@(posedge clk);
	sk <= 1'b1;
	clocks(HALF_SK - 1);
endtask

task automatic select();
	@(posedge clk);
	cs <= 1'b1;
	sk <= 1'b0;
	di <= 1'b0;
	clocks(HALF_SK);
endtask

task automatic deselect();
	int n;
	@(posedge clk);
	cs <= 1'b0;
	sk <= 1'b0;
	di <= 1'b0;
	n = 0;
	do begin
		@(negedge clk);
		n++;
	end while (dout !== 1'b0 && n < DESELECT_LIMIT);
	if (dout !== 1'b0) begin
		errors++;
		$display("do_o still driven %0d cycles after cs_i fell, at %0t ns", n, $time);
	end
	// Output stays low for the whole gap between commands
	for (int i = 0; i < 2 * HALF_SK; i++) begin
		@(negedge clk);
		check_bit(dout, 1'b0, "do_o while deselected");
	end
endtask

task automatic send_command(input opcode_t op, input word_addr_t addr);
	logic [HDR_BITS-1:0] hdr;
	logic s;
	hdr = {op, addr};
	sk_cycle(1'b1, s);
	check_bit(s, 1'b0, "do_o before start bit");
	for (int i = HDR_BITS - 1; i >= 0; i--) begin
		sk_cycle(hdr[i], s);
		check_bit(s, 1'b0, "do_o during header");
	end
endtask

task automatic read_word_bits(output nvm_word_t w);
	logic s;
	w = '0;
	for (int i = 0; i < WORD_W; i++) begin
		sk_cycle(1'b0, s);
		w = {w[WORD_W-2:0], s};
	end
endtask

task automatic read_single(input word_addr_t a, output nvm_word_t w);
	logic s;
	select();
	send_command(OP_READ, a);
	sk_cycle(1'b0, s);
	check_bit(s, 1'b0, "dummy bit");
	read_word_bits(w);
	deselect();
endtask

//////////////////////////////////////////////////////////////
// Directed tests

task automatic test_reset_state();
	int e0;
	logic s;
	nvm_word_t w;
	e0 = errors;
	for (int i = 0; i < 4; i++) begin
		@(negedge clk);
		check_bit(dout, 1'b0, "do_o after reset");
	end
	// A full read command with cs_i low must not start a transfer
	send_command(OP_READ, word_addr_t'(ADDR_VID));
	for (int i = 0; i < WORD_W + 1; i++) begin
		sk_cycle(1'b0, s);
		check_bit(s, 1'b0, "do_o with cs_i low");
	end
	read_single(word_addr_t'(ADDR_MAC0), w);
	check_word(w, expected_word(ADDR_MAC0), "MAC word 0 after idle clocking");
	end_test("reset state", e0);
endtask

task automatic test_single_reads();
	int e0;
	nvm_word_t w;
	e0 = errors;
	for (int a = ADDR_MAC0; a <= ADDR_MAC2; a++) begin
		read_single(word_addr_t'(a), w);
		check_word(w, expected_word(a), $sformatf("MAC word %0d", a));
	end
	end_test("single reads", e0);
endtask

task automatic test_identity();
	int e0;
	nvm_word_t w;
	e0 = errors;
	read_single(word_addr_t'(ADDR_SUB_PID), w);
	check_word(w, SUB_PID, "subsystem device ID");
	read_single(word_addr_t'(ADDR_SUB_VID), w);
	check_word(w, SUB_VID, "subsystem vendor ID");
	read_single(word_addr_t'(ADDR_PID), w);
	check_word(w, PID, "device ID");
	read_single(word_addr_t'(ADDR_VID), w);
	check_word(w, VID, "vendor ID");
	end_test("identity words", e0);
endtask

task automatic test_checksum();
	int e0;
	nvm_word_t w;
	nvm_word_t sum;
	e0 = errors;
	sum = '0;
	for (int a = 0; a < DEPTH; a++) begin
		read_single(word_addr_t'(a), w);
		check_word(w, expected_word(a), $sformatf("word %0d", a));
		sum = sum + w;
	end
	check_word(sum, CHECKSUM_TARGET, "sum of all words");
	end_test("checksum", e0);
endtask

task automatic test_sequential();
	int e0;
	int start;
	int a;
	logic s;
	nvm_word_t w;
	e0 = errors;
	// A random start and then one that runs over the top of the table
	for (int run = 0; run < 2; run++) begin
		start = (run == 0) ? int'($urandom % DEPTH) : DEPTH - 3;
		select();
		send_command(OP_READ, word_addr_t'(start));
		sk_cycle(1'b0, s);
		check_bit(s, 1'b0, "dummy bit");
		for (int k = 0; k < 5; k++) begin
			a = (start + k) % DEPTH;
			read_word_bits(w);
			check_word(w, expected_word(a), $sformatf("sequential word %0d", a));
		end
		deselect();
	end
	end_test("sequential read", e0);
endtask

task automatic test_ignore_abort();
	int e0;
	logic s;
	nvm_word_t w;
	e0 = errors;
	// Opcode 11 is not served
	select();
	send_command(2'b11, word_addr_t'(ADDR_PID));
	for (int i = 0; i < WORD_W + 2; i++) begin
		sk_cycle(1'b0, s);
		check_bit(s, 1'b0, "do_o after ignored opcode");
	end
	deselect();
	// Dummy bit and 7 data bits before cs_i drops
	select();
	send_command(OP_READ, word_addr_t'(ADDR_SUB_VID));
	for (int i = 0; i < 8; i++) begin
		sk_cycle(1'b0, s);
	end
	deselect();
	read_single(word_addr_t'(ADDR_VID), w);
	check_word(w, VID, "vendor ID after abort");
	read_single(word_addr_t'(ADDR_SUB_VID), w);
	check_word(w, SUB_VID, "subsystem vendor ID after abort");
	end_test("ignore and abort", e0);
endtask

`endif

// File: tb_eeprom_config.sv
`timescale 1ns/1ns
`default_nettype none

module tb_eeprom_config;
	import microwire_pkg::*;
	import nvm_map_pkg::*;

	localparam logic [23:0] MAC_OUI = 24'h00A0C9;
	localparam logic [23:0] MAC_NIC = 24'h4D2E17;
	localparam logic [15:0] SUB_PID = 16'h2F41;
	localparam logic [15:0] SUB_VID = 16'h1AF4;
	localparam logic [15:0] PID = 16'h10D3;
	localparam logic [15:0] VID = 16'h7C3E;

	localparam int RESET_CYCLES = 16;
	localparam int RUN_LIMIT = 200000;

	logic clk;
	logic rst;
	logic sk;
	logic cs;
	logic di;
	logic dout;

	int errors;
	int checks;
	int tests_run;
	int tests_failed;

	eeprom_config_top #(
		.MAC_OUI(MAC_OUI),
		.MAC_NIC(MAC_NIC),
		.SUB_PID(SUB_PID),
		.SUB_VID(SUB_VID),
		.PID(PID),
		.VID(VID)
	) dut0 (
		.clk_i(clk),
		.rst_i(rst),
		.sk_i(sk),
		.cs_i(cs),
		.di_i(di),
		.do_o(dout)
	);

	// 10 ns clock
	always #5 clk = ~clk;

	`include "tb_microwire_tasks.svh"

	//////////////////////////////////////////////////////////////
	// Run limit

	initial begin : watchdog
		for (int i = 0; i < RUN_LIMIT; i++) begin
			@(posedge clk);
		end
		$display("Test sequence did not finish within %0d clock cycles", RUN_LIMIT);
		$display("Simulation failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////
	// Test sequence

	initial begin : sequence_main
		clk = 1'b0;
		rst = 1'b1;
		sk = 1'b0;
		cs = 1'b0;
		di = 1'b0;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		void'($urandom(94));

		clocks(RESET_CYCLES);
		rst <= 1'b0;

		test_reset_state();
		test_single_reads();
		test_identity();
		test_checksum();
		test_sequential();
		test_ignore_abort();

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
microwire_pkg.sv
nvm_map_pkg.sv
bit_counter.sv
cmd_shifter.sv
read_shifter.sv
config_rom.sv
microwire_sequencer.sv
eeprom_config_top.sv
tb_eeprom_config.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_eeprom_config
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= Simulation completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard *.svh)
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
